// File: src/la_settings.svh
/*
 * la_capture settings
 * widths and counts shared by the logic analyzer front end
 */

`ifndef LA_SETTINGS_SVH
`define LA_SETTINGS_SVH

// sample width, one bit per channel
`define LA_DW 8

// pre/post trigger counter width
`define LA_CW 16

// decimation counter width
`define LA_DCW 17

// timestamp width
`define LA_TW 64

// number of external trigger lines
`define LA_TN 4

`endif

// File: src/la_pkg.sv
/*
 * la_capture types
 * sample, configuration, control and status records plus encodings
 */

`include "la_settings.svh"

package la_pkg;

  typedef logic [`LA_DW-1:0] sample_t;

  // acquisition phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRE,
    ST_ARMED,
    ST_POST
  } acq_state_e;

  // system bus register offsets
  typedef enum logic [6:0] {
    REG_CTL    = 7'h00,
    REG_MODE   = 7'h04,
    REG_TSEL   = 7'h08,
    REG_PRE    = 7'h10,
    REG_PST    = 7'h14,
    REG_SPRE   = 7'h18,
    REG_SPST   = 7'h1c,
    REG_CTS_LO = 7'h28,
    REG_CTS_HI = 7'h2c,
    REG_MSK    = 7'h40,
    REG_VAL    = 7'h44,
    REG_EPOS   = 7'h48,
    REG_ENEG   = 7'h4c,
    REG_DEC    = 7'h50
  } reg_addr_e;

  typedef struct packed {
    sample_t            cmp_msk;
    sample_t            cmp_val;
    sample_t            edg_pos;
    sample_t            edg_neg;
    logic [`LA_DCW-1:0] dec;
    logic [`LA_CW-1:0]  pre;
    logic [`LA_CW-1:0]  pst;
    // bit 0 detector, bit 1 software, bit 2 external
    logic [2:0]         trg_sel;
    logic               con;
  } la_cfg_t;

  // single cycle pulses from a control write
  typedef struct packed {
    logic rst;
    logic acq;
    logic stp;
    logic swt;
  } la_ctl_t;

  typedef struct packed {
    acq_state_e        state;
    logic              trg;
    logic [`LA_CW-1:0] pre_cnt;
    logic [`LA_CW-1:0] pst_cnt;
    logic [`LA_TW-1:0] cts_trg;
  } la_sts_t;

endpackage

// File: src/la_regset.sv
/*
 * la_capture register set
 * system bus slave holding configuration, control pulses and status
 */

`timescale 1ns/1ps
`include "la_settings.svh"

module la_regset (
  input  logic            bus,
  input  logic            rst_n,
  input  logic            bus_wen,
  input  logic            bus_ren,
  input  logic [31:0]     bus_addr,
  input  logic [31:0]     bus_wdata,
  output logic [31:0]     bus_rdata,
  output logic            bus_ack,
  output la_pkg::la_cfg_t cfg,
  output la_pkg::la_ctl_t ctl,
  input  la_pkg::la_sts_t sts
);

  import la_pkg::*;

  reg_addr_e addr;
  logic      ctl_wr;
  logic      stopped;

  // only the low offset bits are decoded
  assign addr   = reg_addr_e'(bus_addr[6:0]);
  assign ctl_wr = bus_wen && (addr == REG_CTL);

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // ack one cycle after any access
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_wen | bus_ren;
    end
  end

  //////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (bus_wen) begin
      case (addr)
        REG_MODE: cfg.con     <= bus_wdata[0];
        REG_TSEL: cfg.trg_sel <= bus_wdata[2:0];
        REG_PRE:  cfg.pre     <= bus_wdata[`LA_CW-1:0];
        REG_PST:  cfg.pst     <= bus_wdata[`LA_CW-1:0];
        REG_MSK:  cfg.cmp_msk <= sample_t'(bus_wdata);
        REG_VAL:  cfg.cmp_val <= sample_t'(bus_wdata);
        REG_EPOS: cfg.edg_pos <= sample_t'(bus_wdata);
        REG_ENEG: cfg.edg_neg <= sample_t'(bus_wdata);
        REG_DEC:  cfg.dec     <= bus_wdata[`LA_DCW-1:0];
        default: ;
      endcase
    end
  end

  // control pulses, live in the write cycle
  assign ctl.stp = ctl_wr & bus_wdata[3];
  assign ctl.acq = ctl_wr & bus_wdata[2];
  assign ctl.swt = ctl_wr & bus_wdata[1];
  assign ctl.rst = ctl_wr & bus_wdata[0];

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  assign stopped = (sts.state == ST_IDLE);

  // captured on the access, presented with ack
  always_ff @(posedge bus) begin
    if (bus_ren) begin
      case (addr)
        REG_CTL:    bus_rdata <= {28'd0, stopped, ~stopped, sts.trg, 1'b0};
        REG_MODE:   bus_rdata <= 32'(cfg.con);
        REG_TSEL:   bus_rdata <= 32'(cfg.trg_sel);
        REG_PRE:    bus_rdata <= 32'(cfg.pre);
        REG_PST:    bus_rdata <= 32'(cfg.pst);
        REG_SPRE:   bus_rdata <= 32'(sts.pre_cnt);
        REG_SPST:   bus_rdata <= 32'(sts.pst_cnt);
        // trigger timestamp, low word then high word
        REG_CTS_LO: bus_rdata <= 32'(sts.cts_trg);
        REG_CTS_HI: bus_rdata <= 32'(sts.cts_trg >> 32);
        REG_MSK:    bus_rdata <= 32'(cfg.cmp_msk);
        REG_VAL:    bus_rdata <= 32'(cfg.cmp_val);
        REG_EPOS:   bus_rdata <= 32'(cfg.edg_pos);
        REG_ENEG:   bus_rdata <= 32'(cfg.edg_neg);
        REG_DEC:    bus_rdata <= 32'(cfg.dec);
        default:    bus_rdata <= '0;
      endcase
    end
  end

  // back to back acks need an access behind each one
  a_ack_run: assert property (
    @(posedge bus) disable iff (!rst_n)
    (bus_ack && $past(bus_ack)) |->
      ($past(bus_wen || bus_ren) && $past(bus_wen || bus_ren, 2))
  ) else $error("bus_ack held without matching accesses");

endmodule

// File: src/la_decimator.sv
/*
 * la_capture decimator
 * keeps one valid sample in every dec_fac+1
 */

`timescale 1ns/1ps
`include "la_settings.svh"

module la_decimator (
  input  logic               bus,
  input  logic               rst_n,
  input  logic               ctl_rst,
  input  logic [`LA_DCW-1:0] dec_fac,
  input  la_pkg::sample_t    sample_in,
  input  logic               sample_vld,
  output la_pkg::sample_t    dec_data,
  output logic               dec_vld
);

  logic [`LA_DCW-1:0] cnt;
  logic               keep;

  // counter at zero means the next valid sample is kept
  assign keep = sample_vld && (cnt == '0);

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      dec_vld <= 1'b0;
    end else if (ctl_rst) begin
      // restart with the first sample kept
      cnt     <= '0;
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= keep;
      if (keep) begin
        cnt <= dec_fac;
      end else if (sample_vld) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // data only
  always_ff @(posedge bus) begin
    if (keep) begin
      dec_data <= sample_in;
    end
  end

endmodule

// File: src/la_trigger.sv
/*
 * la_capture trigger detector
 * masked value compare and per-bit edge detection on raw samples
 */

`timescale 1ns/1ps

module la_trigger (
  input  logic            bus,
  input  logic            rst_n,
  input  logic            ctl_rst,
  input  la_pkg::sample_t cmp_msk,
  input  la_pkg::sample_t cmp_val,
  input  la_pkg::sample_t edg_pos,
  input  la_pkg::sample_t edg_neg,
  input  la_pkg::sample_t sample_in,
  input  logic            sample_vld,
  output logic            trg_hit
);

  la_pkg::sample_t prev;
  logic            prev_ok;
  logic            cmp_hit;
  logic            pos_hit;
  logic            neg_hit;

  // empty mask disables the comparator
  assign cmp_hit = (|cmp_msk) && ((sample_in & cmp_msk) == (cmp_val & cmp_msk));

  // edges need a previous sample to compare against
  assign pos_hit = prev_ok && (|(edg_pos & ~prev & sample_in));
  assign neg_hit = prev_ok && (|(edg_neg & prev & ~sample_in));

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      prev    <= '0;
      prev_ok <= 1'b0;
      trg_hit <= 1'b0;
    end else if (ctl_rst) begin
      prev    <= '0;
      prev_ok <= 1'b0;
      trg_hit <= 1'b0;
    end else begin
      // hit lines up with the decimator output
      trg_hit <= sample_vld && (cmp_hit || pos_hit || neg_hit);
      if (sample_vld) begin
        prev    <= sample_in;
        prev_ok <= 1'b1;
      end
    end
  end

endmodule

// File: src/la_acquire.sv
/*
 * la_capture acquisition controller
 * pre/armed/post phases, output stream, trigger timestamp, interrupts
 */

`timescale 1ns/1ps
`include "la_settings.svh"

module la_acquire (
  input  logic              bus,
  input  logic              rst_n,
  input  la_pkg::la_ctl_t   ctl,
  input  la_pkg::la_cfg_t   cfg,
  input  la_pkg::sample_t   dec_data,
  input  logic              dec_vld,
  input  logic              trg_hit,
  input  logic [`LA_TN-1:0] trg_ext,
  input  logic [`LA_TW-1:0] cts,
  output la_pkg::sample_t   out_data,
  output logic              out_vld,
  output logic              out_last,
  output logic              irq_trg,
  output logic              irq_stp,
  output la_pkg::la_sts_t   sts
);

  import la_pkg::*;

  acq_state_e        state;
  logic              trg_flag;
  logic [`LA_CW-1:0] pre_cnt;
  logic [`LA_CW-1:0] pst_cnt;
  logic [`LA_TW-1:0] cts_trg;
  logic [`LA_CW:0]   pre_inc;
  logic [`LA_CW:0]   pst_inc;
  logic              ctl_any;
  logic              trg_sel_hit;
  logic              trg_acc;
  logic              post_end;

  assign ctl_any = ctl.rst | ctl.stp | ctl.acq;
  // extra bit so the compare with a full scale count does not wrap
  assign pre_inc = {1'b0, pre_cnt} + 1'b1;
  assign pst_inc = {1'b0, pst_cnt} + 1'b1;

  // selected trigger sources
  assign trg_sel_hit = (cfg.trg_sel[0] & trg_hit) | (cfg.trg_sel[1] & ctl.swt) |
                       (cfg.trg_sel[2] & (|trg_ext));
  assign trg_acc     = (state == ST_ARMED) && trg_sel_hit && !ctl_any;

  // last post-trigger sample, never in continuous mode
  assign post_end = (state == ST_POST) && dec_vld && !cfg.con && !ctl.rst &&
                    (pst_inc >= {1'b0, cfg.pst});

  //////////////////////////////////////////////////
  // phase FSM
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      trg_flag <= 1'b0;
      pre_cnt  <= '0;
      pst_cnt  <= '0;
      cts_trg  <= '0;
    end else if (ctl.rst) begin
      state    <= ST_IDLE;
      trg_flag <= 1'b0;
      pre_cnt  <= '0;
      pst_cnt  <= '0;
    end else if (ctl.stp) begin
      state <= ST_IDLE;
    end else if (ctl.acq) begin
      state    <= ST_PRE;
      trg_flag <= 1'b0;
      pre_cnt  <= '0;
      pst_cnt  <= '0;
    end else begin
      case (state)
        ST_PRE: begin
          if (cfg.pre == '0) begin
            state <= ST_ARMED;
          end else if (dec_vld) begin
            pre_cnt <= pre_inc[`LA_CW-1:0];
            if (pre_inc >= {1'b0, cfg.pre}) begin
              state <= ST_ARMED;
            end
          end
        end
        ST_ARMED: begin
          // timestamp taken in the acceptance cycle
          if (trg_acc) begin
            state    <= ST_POST;
            trg_flag <= 1'b1;
            cts_trg  <= cts;
          end
        end
        ST_POST: begin
          if (dec_vld) begin
            pst_cnt <= pst_inc[`LA_CW-1:0];
            if (post_end) begin
              state <= ST_IDLE;
            end
          end
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // output stream and interrupts
  //////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_vld  <= 1'b0;
      out_last <= 1'b0;
      irq_trg  <= 1'b0;
      irq_stp  <= 1'b0;
    end else begin
      // every phase but idle forwards
      out_vld  <= dec_vld && (state != ST_IDLE) && !ctl.rst;
      out_last <= post_end;
      irq_stp  <= post_end;
      irq_trg  <= trg_acc;
    end
  end

  always_ff @(posedge bus) begin
    if (dec_vld) begin
      out_data <= dec_data;
    end
  end

  assign sts.state   = state;
  assign sts.trg     = trg_flag;
  assign sts.pre_cnt = pre_cnt;
  assign sts.pst_cnt = pst_cnt;
  assign sts.cts_trg = cts_trg;

  a_last_vld: assert property (
    @(posedge bus) disable iff (!rst_n) out_last |-> out_vld
  ) else $error("out_last without out_vld");

  a_post_trg: assert property (
    @(posedge bus) disable iff (!rst_n) (state == ST_POST) |-> trg_flag
  ) else $error("post phase entered without trigger");

endmodule

// File: src/la_top.sv
/*
 * la_capture top
 * register set, decimator, trigger detector and acquisition controller
 */

`timescale 1ns/1ps
`include "la_settings.svh"

module la_top (
  input  logic              bus,
  input  logic              rst_n,
  // raw sample stream
  input  la_pkg::sample_t   sample_in,
  input  logic              sample_vld,
  input  logic [`LA_TN-1:0] trg_ext,
  // system bus
  input  logic              bus_wen,
  input  logic              bus_ren,
  input  logic [31:0]       bus_addr,
  input  logic [31:0]       bus_wdata,
  output logic [31:0]       bus_rdata,
  output logic              bus_ack,
  input  logic [`LA_TW-1:0] cts,
  // captured stream
  output la_pkg::sample_t   out_data,
  output logic              out_vld,
  output logic              out_last,
  output logic              trg_out,
  output logic              trg_swo,
  output logic              irq_trg,
  output logic              irq_stp
);

  import la_pkg::*;

  la_cfg_t cfg;
  la_ctl_t ctl;
  la_sts_t sts;
  sample_t dec_data;
  logic    dec_vld;
  logic    trg_hit;

  la_regset regset0 (
    .bus       (bus),
    .rst_n     (rst_n),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .cfg       (cfg),
    .ctl       (ctl),
    .sts       (sts)
  );

  la_decimator dec0 (
    .bus        (bus),
    .rst_n      (rst_n),
    .ctl_rst    (ctl.rst),
    .dec_fac    (cfg.dec),
    .sample_in  (sample_in),
    .sample_vld (sample_vld),
    .dec_data   (dec_data),
    .dec_vld    (dec_vld)
  );

  // sees every raw sample, not just the kept ones
  la_trigger trg0 (
    .bus        (bus),
    .rst_n      (rst_n),
    .ctl_rst    (ctl.rst),
    .cmp_msk    (cfg.cmp_msk),
    .cmp_val    (cfg.cmp_val),
    .edg_pos    (cfg.edg_pos),
    .edg_neg    (cfg.edg_neg),
    .sample_in  (sample_in),
    .sample_vld (sample_vld),
    .trg_hit    (trg_hit)
  );

  la_acquire acq0 (
    .bus      (bus),
    .rst_n    (rst_n),
    .ctl      (ctl),
    .cfg      (cfg),
    .dec_data (dec_data),
    .dec_vld  (dec_vld),
    .trg_hit  (trg_hit),
    .trg_ext  (trg_ext),
    .cts      (cts),
    .out_data (out_data),
    .out_vld  (out_vld),
    .out_last (out_last),
    .irq_trg  (irq_trg),
    .irq_stp  (irq_stp),
    .sts      (sts)
  );

  // trigger lines out for chaining
  assign trg_out = trg_hit;
  assign trg_swo = ctl.swt;

endmodule

// File: verif/la_tb.sv
/*
 * la_capture testbench
 * bus register checks, random sample stream, cycle model of trigger,
 * decimator and acquisition phases, compared every cycle
 */

`timescale 1ns/1ps
`include "la_settings.svh"

module la_tb;

  import la_pkg::*;

  // cycle model state, one step per clock
  typedef struct packed {
    la_cfg_t           cfg;
    acq_state_e        state;
    logic [`LA_CW-1:0] prec;
    logic [`LA_CW-1:0] pstc;
    logic [`LA_DCW-1:0] phase;
    sample_t           prev;
    logic              prev_ok;
    logic              trg;
    logic              dvld;
    sample_t           ddata;
    logic              ovld;
    sample_t           odata;
    logic              olast;
    logic              itrg;
    logic              istp;
  } model_t;

  logic              bus;
  logic              rst_n;
  sample_t           sample_in;
  logic              sample_vld;
  logic [`LA_TN-1:0] trg_ext;
  logic              bus_wen;
  logic              bus_ren;
  logic [31:0]       bus_addr;
  logic [31:0]       bus_wdata;
  logic [31:0]       bus_rdata;
  logic              bus_ack;
  logic [`LA_TW-1:0] cts;
  sample_t           out_data;
  logic              out_vld;
  logic              out_last;
  logic              trg_out;
  logic              trg_swo;
  logic              irq_trg;
  logic              irq_stp;

  model_t            mdl;
  logic [31:0]       lcg_state;
  logic [31:0]       rnd;
  logic              stim_on;
  logic [`LA_TW-1:0] cts_edge;
  logic [`LA_TW-1:0] trg_cts;
  int                err_cnt;
  int                fail_cnt;
  int                hit_cnt;
  int                out_cnt;
  int                last_cnt;
  int                itrg_cnt;
  int                post_seen;
  int                post_at_stp;
  logic              grab_on;
  logic              gin_ok;
  logic              gout_ok;
  sample_t           gin;
  sample_t           gout;

  la_top dut0 (
    .bus        (bus),
    .rst_n      (rst_n),
    .sample_in  (sample_in),
    .sample_vld (sample_vld),
    .trg_ext    (trg_ext),
    .bus_wen    (bus_wen),
    .bus_ren    (bus_ren),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .bus_ack    (bus_ack),
    .cts        (cts),
    .out_data   (out_data),
    .out_vld    (out_vld),
    .out_last   (out_last),
    .trg_out    (trg_out),
    .trg_swo    (trg_swo),
    .irq_trg    (irq_trg),
    .irq_stp    (irq_stp)
  );

  // 40 ns period
  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // next clock of the front end, from the inputs seen before the edge
  function automatic model_t model_step(input model_t m, input sample_t smp, input logic vld,
                                        input logic [`LA_TN-1:0] ext, input logic wen,
                                        input logic [6:0] addr, input logic [31:0] wd);
    model_t          n;
    logic            ctl_wr;
    logic            c_rst;
    logic            c_acq;
    logic            c_stp;
    logic            c_swt;
    logic            sel;
    logic            acc;
    logic            last;
    logic            hit;
    logic            keep;
    n      = m;
    ctl_wr = wen && (addr == REG_CTL);
    c_rst  = ctl_wr && wd[0];
    c_swt  = ctl_wr && wd[1];
    c_acq  = ctl_wr && wd[2];
    c_stp  = ctl_wr && wd[3];
    // trigger accepted only while armed
    sel = (m.cfg.trg_sel[0] && m.trg) || (m.cfg.trg_sel[1] && c_swt) ||
          (m.cfg.trg_sel[2] && (ext != '0));
    acc = (m.state == ST_ARMED) && sel && !(c_rst || c_stp || c_acq);
    // sample number pst after the trigger closes the capture
    last  = (m.state == ST_POST) && m.dvld && !m.cfg.con && !c_rst &&
            (int'(m.pstc) + 1 >= int'(m.cfg.pst));
    // masked compare plus rising and falling edges
    hit = vld && (((m.cfg.cmp_msk != '0) && (((smp ^ m.cfg.cmp_val) & m.cfg.cmp_msk) == '0)) ||
          (m.prev_ok && ((~m.prev & smp & m.cfg.edg_pos) != '0)) ||
          (m.prev_ok && ((m.prev & ~smp & m.cfg.edg_neg) != '0)));
    keep = vld && (m.phase == '0);
    n.ovld  = m.dvld && (m.state != ST_IDLE) && !c_rst;
    if (m.dvld) begin
      n.odata = m.ddata;
    end
    n.olast = last;
    n.istp  = last;
    n.itrg  = acc;
    if (c_rst) begin
      n.state = ST_IDLE;
      n.prec  = '0;
      n.pstc  = '0;
    end else if (c_stp) begin
      n.state = ST_IDLE;
    end else if (c_acq) begin
      n.state = ST_PRE;
      n.prec  = '0;
      n.pstc  = '0;
    end else begin
      case (m.state)
        ST_PRE: begin
          if (m.cfg.pre == '0) begin
            n.state = ST_ARMED;
          end else if (m.dvld) begin
            n.prec = m.prec + 1'b1;
            if (int'(m.prec) + 1 >= int'(m.cfg.pre)) begin
              n.state = ST_ARMED;
            end
          end
        end
        ST_ARMED: begin
          if (acc) begin
            n.state = ST_POST;
          end
        end
        ST_POST: begin
          if (m.dvld) begin
            n.pstc = m.pstc + 1'b1;
            if (last) begin
              n.state = ST_IDLE;
            end
          end
        end
        default: ;
      endcase
    end
    // keep-one-of-N as a phase counting up to dec
    if (c_rst) begin
      n.phase   = '0;
      n.dvld    = 1'b0;
      n.prev    = '0;
      n.prev_ok = 1'b0;
      n.trg     = 1'b0;
    end else begin
      n.trg  = hit;
      n.dvld = keep;
      if (keep) begin
        n.ddata = smp;
      end
      if (vld) begin
        n.phase   = (m.phase >= m.cfg.dec) ? '0 : m.phase + 1'b1;
        n.prev    = smp;
        n.prev_ok = 1'b1;
      end
    end
    // writes land on the same edge
    if (wen) begin
      case (addr)
        REG_MODE: n.cfg.con     = wd[0];
        REG_TSEL: n.cfg.trg_sel = wd[2:0];
        REG_PRE:  n.cfg.pre     = wd[`LA_CW-1:0];
        REG_PST:  n.cfg.pst     = wd[`LA_CW-1:0];
        REG_MSK:  n.cfg.cmp_msk = wd[`LA_DW-1:0];
        REG_VAL:  n.cfg.cmp_val = wd[`LA_DW-1:0];
        REG_EPOS: n.cfg.edg_pos = wd[`LA_DW-1:0];
        REG_ENEG: n.cfg.edg_neg = wd[`LA_DW-1:0];
        REG_DEC:  n.cfg.dec     = wd[`LA_DCW-1:0];
        default: ;
      endcase
    end
    return n;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      $display("ERR %s exp/got %h/%h at %0t", name, exp, got, $time);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and compare processes
  //////////////////////////////////////////////////

  // samples and timestamp change shortly after the edge
  always @(posedge bus) begin
    #2;
    cts = cts + 1'b1;
    if (stim_on) begin
      rnd        = lcg_next();
      sample_vld = (rnd[31:30] != 2'b00);
      sample_in  = rnd[23:16];
    end else begin
      sample_vld = 1'b0;
    end
  end

  // timestamp as the DUT sees it on the edge
  always @(posedge bus) begin
    cts_edge <= cts;
  end

  // outputs settled by the falling edge
  always @(negedge bus) begin
    if (!rst_n) begin
      mdl = '0;
    end else begin
      compare("trg_out", mdl.trg, trg_out);
      compare("out_vld", mdl.ovld, out_vld);
      compare("out_last", mdl.olast, out_last);
      compare("irq_trg", mdl.itrg, irq_trg);
      compare("irq_stp", mdl.istp, irq_stp);
      if (mdl.ovld) begin
        compare("out_data", mdl.odata, out_data);
      end
      compare("trg_swo", bus_wen && (bus_addr[6:0] == REG_CTL) && bus_wdata[1], trg_swo);
      if (trg_out) hit_cnt++;
      if (out_vld) out_cnt++;
      if (out_last) last_cnt++;
      // post samples counted after the trigger beat
      if (irq_trg) begin
        trg_cts   = cts_edge;
        post_seen = 0;
        itrg_cnt++;
      end else if (out_vld) begin
        post_seen++;
      end
      if (irq_stp) post_at_stp = post_seen;
      if (grab_on && !gin_ok && sample_vld) begin
        gin    = sample_in;
        gin_ok = 1'b1;
      end
      if (grab_on && !gout_ok && out_vld) begin
        gout    = out_data;
        gout_ok = 1'b1;
      end
      mdl = model_step(mdl, sample_in, sample_vld, trg_ext, bus_wen, bus_addr[6:0], bus_wdata);
    end
  end

  //////////////////////////////////////////////////
  // bus and sequencing tasks
  //////////////////////////////////////////////////

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    while (!bus_ack && n < 16) begin
      @(negedge bus);
      n++;
    end
    if (!bus_ack) begin
      $display("no bus ack for %s", what);
      fail_cnt++;
    end
  endtask

  task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
    @(posedge bus);
    #2;
    bus_wen   = 1'b1;
    bus_addr  = {25'd0, addr};
    bus_wdata = data;
    @(posedge bus);
    #2;
    bus_wen = 1'b0;
    wait_ack("write");
  endtask

  task automatic bus_read(input logic [6:0] addr, output logic [31:0] data);
    @(posedge bus);
    #2;
    bus_ren  = 1'b1;
    bus_addr = {25'd0, addr};
    @(posedge bus);
    #2;
    bus_ren = 1'b0;
    wait_ack("read");
    data = bus_rdata;
  endtask

  // random write, read back masked to the field
  task automatic rw_check(input logic [6:0] addr, input logic [31:0] mask);
    logic [31:0] wr;
    logic [31:0] rd;
    wr = lcg_next();
    bus_write(addr, wr);
    bus_read(addr, rd);
    compare($sformatf("reg_%02h", addr), wr & mask, rd);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge bus);
  endtask

  task automatic set_stim(input logic on);
    @(negedge bus);
    stim_on = on;
  endtask

  task automatic wait_irq(input logic use_stp, input string what);
    int n;
    n = 0;
    do begin
      @(negedge bus);
      n++;
    end while (!(use_stp ? irq_stp : irq_trg) && n < 2000);
    if (!(use_stp ? irq_stp : irq_trg)) begin
      $display("timeout waiting for %s", what);
      fail_cnt++;
    end
  endtask

  task automatic arm_grab();
    gin_ok  = 1'b0;
    gout_ok = 1'b0;
    grab_on = 1'b1;
  endtask

  task automatic check_grab(input string what);
    grab_on = 1'b0;
    if (!gin_ok || !gout_ok) begin
      $display("no sample reached the output for %s", what);
      fail_cnt++;
    end else begin
      compare(what, gin, gout);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    int          cnt0;
    int          cnt1;
    rst_n      = 1'b0;
    sample_in  = '0;
    sample_vld = 1'b0;
    trg_ext    = '0;
    bus_wen    = 1'b0;
    bus_ren    = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    cts        = 64'h0000_0002_ffff_ff00;
    lcg_state  = 32'h40b6d549;
    stim_on    = 1'b0;
    grab_on    = 1'b0;
    gin_ok     = 1'b0;
    gout_ok    = 1'b0;
    err_cnt    = 0;
    fail_cnt   = 0;
    hit_cnt    = 0;
    out_cnt    = 0;
    last_cnt   = 0;
    itrg_cnt   = 0;
    post_seen  = 0;
    post_at_stp = -1;
    repeat (16) @(posedge bus);
    #2;
    rst_n = 1'b1;

    // register readback, masked widths
    rw_check(REG_MODE, 32'h1);
    rw_check(REG_TSEL, 32'h7);
    rw_check(REG_PRE, 32'hffff);
    rw_check(REG_PST, 32'hffff);
    rw_check(REG_MSK, 32'hff);
    rw_check(REG_VAL, 32'hff);
    rw_check(REG_EPOS, 32'hff);
    rw_check(REG_ENEG, 32'hff);
    rw_check(REG_DEC, 32'h1ffff);
    bus_read(7'h24, rd);
    compare("unmapped_24", 32'h0, rd);
    bus_read(7'h30, rd);
    compare("unmapped_30", 32'h0, rd);
    bus_read(7'h5c, rd);
    compare("unmapped_5c", 32'h0, rd);

    // detector on the raw stream, idle acquisition
    bus_write(REG_DEC, 32'h0);
    bus_write(REG_MSK, 32'h0c);
    bus_write(REG_VAL, 32'h04);
    bus_write(REG_EPOS, 32'h80);
    bus_write(REG_ENEG, 32'h01);
    bus_write(REG_TSEL, 32'h1);
    set_stim(1'b1);
    idle_cycles(200);
    set_stim(1'b0);
    if (hit_cnt == 0) begin
      $display("detector never fired on the random stream");
      fail_cnt++;
    end

    // keep one in four, software trigger, continuous
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_DEC, 32'h3);
    bus_write(REG_TSEL, 32'h2);
    bus_write(REG_MODE, 32'h1);
    bus_write(REG_PRE, 32'h2);
    bus_write(REG_PST, 32'h4);
    bus_write(REG_CTL, 32'h4);
    arm_grab();
    cnt0 = out_cnt;
    cnt1 = itrg_cnt;
    set_stim(1'b1);
    idle_cycles(40);
    bus_write(REG_CTL, 32'h2);
    idle_cycles(120);
    bus_write(REG_CTL, 32'h8);
    set_stim(1'b0);
    check_grab("dec_first");
    compare("dec_swt_irq", cnt1 + 1, itrg_cnt);
    if (out_cnt - cnt0 < 10) begin
      $display("too few decimated samples forwarded");
      fail_cnt++;
    end

    // pre/post capture on the detector
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_DEC, 32'h0);
    bus_write(REG_MSK, 32'h07);
    bus_write(REG_VAL, 32'h05);
    bus_write(REG_EPOS, 32'h0);
    bus_write(REG_ENEG, 32'h0);
    bus_write(REG_TSEL, 32'h1);
    bus_write(REG_MODE, 32'h0);
    bus_write(REG_PRE, 32'h5);
    bus_write(REG_PST, 32'h6);
    cnt1 = last_cnt;
    bus_write(REG_CTL, 32'h4);
    arm_grab();
    set_stim(1'b1);
    wait_irq(1'b1, "capture stop");
    set_stim(1'b0);
    idle_cycles(4);
    check_grab("cap_first");
    compare("post_samples", 6, post_at_stp);
    compare("last_count", cnt1 + 1, last_cnt);
    // stopped and triggered, not running
    bus_read(REG_CTL, rd);
    compare("ctl_status", 32'ha, rd);
    bus_read(REG_SPST, rd);
    compare("post_count", 32'h6, rd);
    bus_read(REG_SPRE, rd);
    compare("pre_count", 32'h5, rd);

    // external line, trigger timestamp
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_TSEL, 32'h4);
    bus_write(REG_PRE, 32'h0);
    bus_write(REG_PST, 32'h3);
    bus_write(REG_CTL, 32'h4);
    idle_cycles(3);
    #2;
    trg_ext = 4'b0100;
    cnt1 = itrg_cnt;
    wait_irq(1'b0, "external trigger");
    @(posedge bus);
    #2;
    trg_ext = '0;
    compare("ext_irq", cnt1 + 1, itrg_cnt);
    bus_read(REG_CTS_LO, rd);
    compare("cts_lo", trg_cts[31:0], rd);
    bus_read(REG_CTS_HI, rd);
    compare("cts_hi", trg_cts[63:32], rd);

    // stop in continuous mode, then restart after a reset pulse
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_DEC, 32'h2);
    bus_write(REG_TSEL, 32'h2);
    bus_write(REG_MODE, 32'h1);
    bus_write(REG_PRE, 32'h1);
    bus_write(REG_PST, 32'h2);
    bus_write(REG_CTL, 32'h4);
    set_stim(1'b1);
    idle_cycles(30);
    bus_write(REG_CTL, 32'h2);
    idle_cycles(40);
    cnt1 = last_cnt;
    bus_write(REG_CTL, 32'h8);
    idle_cycles(3);
    cnt0 = out_cnt;
    idle_cycles(30);
    compare("out_after_stop", cnt0, out_cnt);
    compare("last_after_stop", cnt1, last_cnt);
    set_stim(1'b0);
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_CTL, 32'h4);
    arm_grab();
    set_stim(1'b1);
    idle_cycles(40);
    set_stim(1'b0);
    check_grab("restart_first");

    idle_cycles(5);
    $display("mismatches %0d, other failures %0d", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: la_capture.f
+incdir+src
src/la_pkg.sv
src/la_regset.sv
src/la_decimator.sv
src/la_trigger.sv
src/la_acquire.sv
src/la_top.sv
verif/la_tb.sv
